//--- rtl/displayPkg.sv
package displayPkg;

    //////////////////////////////////////////////////////////////////////
    // pixel side types

    // beam position or object coordinate
    typedef logic [9:0] coordT;

    // colour select sent on to the palette
    typedef logic [2:0] colorSelT;

    // one drawable block
    typedef struct packed {
        coordT    hStart;
        coordT    vStart;
        coordT    width;
        coordT    height;
        colorSelT color;
        logic     visible;
    } objAttrT;

    //////////////////////////////////////////////////////////////////////
    // 640x480 visible window, in raw counter units

    localparam coordT hFirst = 10'd144;
    localparam coordT hLast  = 10'd784;
    localparam coordT vFirst = 10'd35;
    localparam coordT vLast  = 10'd515;

    // frame drawn around the inside of the window
    localparam coordT    borderThick = 10'd8;
    localparam colorSelT borderColor = 3'd6;
    localparam colorSelT backColor   = 3'd0;

    //////////////////////////////////////////////////////////////////////
    // object set

    localparam int wallCount   = 4;
    localparam int scrollCount = 4;
    // player plus walls plus scrolls
    localparam int objCount    = 1 + wallCount + scrollCount;

    // entry 0 is the player, walls follow, then scrolls
    // the index also sets draw priority, lowest wins
    typedef objAttrT [objCount-1:0] objAttrTableT;

endpackage

//--- rtl/busPkg.sv
package busPkg;

    //////////////////////////////////////////////////////////////////////
    // Wishbone widths

    // word address, object index above field code
    typedef logic [6:0]  wbAddrT;
    typedef logic [31:0] wbDataT;

    // the two halves of a word address
    typedef logic [3:0] wbIndexT;
    typedef logic [2:0] wbFieldT;

    // master to slave
    typedef struct packed {
        logic   cyc;
        logic   stb;
        logic   we;
        wbAddrT adr;
        wbDataT dat;
    } wbReqT;

    // slave to master
    typedef struct packed {
        logic   ack;
        wbDataT dat;
    } wbRspT;

    //////////////////////////////////////////////////////////////////////
    // register map, per object

    localparam wbFieldT fieldHStart = 3'd0;
    localparam wbFieldT fieldVStart = 3'd1;
    localparam wbFieldT fieldWidth  = 3'd2;
    localparam wbFieldT fieldHeight = 3'd3;
    localparam wbFieldT fieldStyle  = 3'd4;

    // layout of the style word
    localparam int styleColorLsb   = 0;
    localparam int styleVisibleBit = 8;

endpackage

//--- rtl/objectRegs.sv
`timescale 1ns/10ps

module objectRegs
    import displayPkg::*;
    import busPkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  wbReqT        wbReq,
    output wbRspT        wbRsp,
    output objAttrTableT objTable
);

    wbIndexT reqIndex;
    wbFieldT reqField;
    logic    indexValid;
    logic    strobe;
    logic    ackQ;
    objAttrT selAttr;
    wbDataT  readData;
    wbDataT  datQ;

    //////////////////////////////////////////////////////////////////////
    // address decode

    assign reqIndex = wbReq.adr[$bits(wbAddrT)-1:$bits(wbFieldT)];
    assign reqField = wbReq.adr[$bits(wbFieldT)-1:0];

    // indices past the last scroll are holes in the map
    assign indexValid = reqIndex < objCount;

    // new request, not the tail of one already acked
    assign strobe = wbReq.cyc && wbReq.stb && !ackQ;

    //////////////////////////////////////////////////////////////////////
    // attribute table and ack

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ackQ     <= 1'b0;
            objTable <= '0;
        end
        else
        begin
            ackQ <= strobe;
            if (strobe && wbReq.we && indexValid)
            begin
                case (reqField)
                    fieldHStart:
                        objTable[reqIndex].hStart <= wbReq.dat[$bits(coordT)-1:0];
                    fieldVStart:
                        objTable[reqIndex].vStart <= wbReq.dat[$bits(coordT)-1:0];
                    fieldWidth:
                        objTable[reqIndex].width  <= wbReq.dat[$bits(coordT)-1:0];
                    fieldHeight:
                        objTable[reqIndex].height <= wbReq.dat[$bits(coordT)-1:0];
                    fieldStyle:
                    begin
                        objTable[reqIndex].color <=
                            wbReq.dat[styleColorLsb +: $bits(colorSelT)];
                        objTable[reqIndex].visible <= wbReq.dat[styleVisibleBit];
                    end
                    default:
                    begin
                        // unmapped field, write dropped
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read mux

    always_comb
    begin
        selAttr  = '0;
        readData = '0;
        if (indexValid)
        begin
            selAttr = objTable[reqIndex];
        end
        case (reqField)
            fieldHStart: readData[$bits(coordT)-1:0] = selAttr.hStart;
            fieldVStart: readData[$bits(coordT)-1:0] = selAttr.vStart;
            fieldWidth:  readData[$bits(coordT)-1:0] = selAttr.width;
            fieldHeight: readData[$bits(coordT)-1:0] = selAttr.height;
            fieldStyle:
            begin
                readData[styleColorLsb +: $bits(colorSelT)] = selAttr.color;
                readData[styleVisibleBit] = selAttr.visible;
            end
            default:
            begin
                readData = '0;
            end
        endcase
    end

    // captured with the strobe, presented in the ack cycle
    always_ff @(posedge clk)
    begin
        if (strobe)
        begin
            datQ <= readData;
        end
    end

    assign wbRsp.ack = ackQ;
    assign wbRsp.dat = datQ;

endmodule

//--- rtl/objectHit.sv
`timescale 1ns/10ps

module objectHit
    import displayPkg::*;
(
    input  objAttrT attr,
    input  coordT   hCount,
    input  coordT   vCount,
    output logic    hit
);

    // wide enough for start + window offset + size at full scale
    logic [$bits(coordT)+1:0] hLow;
    logic [$bits(coordT)+1:0] hHigh;
    logic [$bits(coordT)+1:0] vLow;
    logic [$bits(coordT)+1:0] vHigh;
    logic [$bits(coordT)+1:0] hPos;
    logic [$bits(coordT)+1:0] vPos;
    logic                     hInside;
    logic                     vInside;

    // object start is relative to the top left visible pixel
    assign hLow  = {2'b00, attr.hStart} + {2'b00, hFirst};
    assign vLow  = {2'b00, attr.vStart} + {2'b00, vFirst};
    assign hHigh = hLow + {2'b00, attr.width};
    assign vHigh = vLow + {2'b00, attr.height};

    assign hPos = {2'b00, hCount};
    assign vPos = {2'b00, vCount};

    // both edges count as inside
    assign hInside = (hPos >= hLow) && (hPos <= hHigh);
    assign vInside = (vPos >= vLow) && (vPos <= vHigh);

    assign hit = attr.visible && hInside && vInside;

endmodule

//--- rtl/pixelCompositor.sv
`timescale 1ns/10ps

module pixelCompositor
    import displayPkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  coordT               hCount,
    input  coordT               vCount,
    input  logic [objCount-1:0] hits,
    input  objAttrTableT        objTable,
    output colorSelT            sel
);

    logic     outside;
    logic     inBorder;
    colorSelT objColor;
    colorSelT nextSel;

    //////////////////////////////////////////////////////////////////////
    // window and border

    assign outside = (hCount < hFirst) || (hCount > hLast) ||
                     (vCount < vFirst) || (vCount > vLast);

    // only meaningful once outside is known to be low
    assign inBorder = (hCount <= hFirst + borderThick) ||
                      (hCount >= hLast - borderThick) ||
                      (vCount <= vFirst + borderThick) ||
                      (vCount >= vLast - borderThick);

    //////////////////////////////////////////////////////////////////////
    // object priority

    // walk from the top index down so the lowest hit is left standing
    always_comb
    begin
        objColor = backColor;
        for (int i = objCount - 1; i >= 0; i--)
        begin
            if (hits[i])
            begin
                objColor = objTable[i].color;
            end
        end
    end

    always_comb
    begin
        if (outside)
        begin
            nextSel = backColor;
        end
        else if (inBorder)
        begin
            nextSel = borderColor;
        end
        else
        begin
            nextSel = objColor;
        end
    end

    // one cycle from beam position to select
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sel <= '0;
        end
        else
        begin
            sel <= nextSel;
        end
    end

endmodule

//--- rtl/compareDisp.sv
`timescale 1ns/10ps

module compareDisp
    import displayPkg::*;
    import busPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  coordT    hCount,
    input  coordT    vCount,
    input  wbReqT    wbReq,
    output wbRspT    wbRsp,
    output colorSelT sel
);

    objAttrTableT        objTable;
    logic [objCount-1:0] hits;

    //////////////////////////////////////////////////////////////////////
    // host side attribute table

    objectRegs objectRegs_inst
    (
        .clk      (clk),
        .reset    (reset),
        .wbReq    (wbReq),
        .wbRsp    (wbRsp),
        .objTable (objTable)
    );

    //////////////////////////////////////////////////////////////////////
    // one rectangle test per table entry

    for (genvar i = 0; i < objCount; i++)
    begin : genHit
        objectHit objectHit_inst
        (
            .attr   (objTable[i]),
            .hCount (hCount),
            .vCount (vCount),
            .hit    (hits[i])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // final select

    // colours come straight from the table, hits only pick the winner
    pixelCompositor pixelCompositor_inst
    (
        .clk      (clk),
        .reset    (reset),
        .hCount   (hCount),
        .vCount   (vCount),
        .hits     (hits),
        .objTable (objTable),
        .sel      (sel)
    );

endmodule

//--- verification/compareDispTb.sv
`timescale 1ns/10ps

module compareDispTb
    import displayPkg::*;
    import busPkg::*;
();

    typedef logic [1:0] rowKindT;

    localparam rowKindT kindWrite = 2'd0;
    localparam rowKindT kindRead  = 2'd1;
    localparam rowKindT kindProbe = 2'd2;

    localparam int clkPeriod  = 100;
    localparam int ackTimeout = 16;

    // one line of the stimulus table, name kept alongside
    typedef struct packed {
        rowKindT kind;
        wbAddrT  adr;
        wbDataT  dat;
        coordT   hPos;
        coordT   vPos;
        wbDataT  expected;
    } rowT;

    logic     clk;
    logic     reset;
    coordT    hCount;
    coordT    vCount;
    wbReqT    wbReq;
    wbRspT    wbRsp;
    colorSelT sel;

    rowT   rows[$];
    string rowNames[$];

    compareDisp compareDisp_inst
    (
        .clk    (clk),
        .reset  (reset),
        .hCount (hCount),
        .vCount (vCount),
        .wbReq  (wbReq),
        .wbRsp  (wbRsp),
        .sel    (sel)
    );

    always #(clkPeriod / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // register map helpers

    function automatic wbAddrT regAddr(input wbIndexT index, input wbFieldT field);
        wbAddrT adr;
        adr = {index, field};
        return adr;
    endfunction

    // walls sit right after the player
    function automatic wbIndexT wallIndex(input int n);
        wbIndexT index;
        index = wbIndexT'(1 + n);
        return index;
    endfunction

    // scrolls follow the last wall
    function automatic wbIndexT scrollIndex(input int n);
        wbIndexT index;
        index = wbIndexT'(1 + wallCount + n);
        return index;
    endfunction

    function automatic wbDataT styleWord(input colorSelT color, input logic visible);
        wbDataT word;
        word = '0;
        word[styleColorLsb +: $bits(colorSelT)] = color;
        word[styleVisibleBit] = visible;
        return word;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // failure reporting and the value check

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input wbDataT expected, input wbDataT actual);
        if (actual !== expected)
        begin
            reportFailure($sformatf("FAIL %s: expected 0x%0h, actual 0x%0h",
                name, expected, actual));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // table building

    task automatic addRow(input rowKindT kind, input string name, input wbAddrT adr,
        input wbDataT dat, input coordT hPos, input coordT vPos, input wbDataT expected);
        rowT row;
        row.kind     = kind;
        row.adr      = adr;
        row.dat      = dat;
        row.hPos     = hPos;
        row.vPos     = vPos;
        row.expected = expected;
        rows.push_back(row);
        rowNames.push_back(name);
    endtask

    task automatic addWrite(input string name, input wbAddrT adr, input wbDataT dat);
        addRow(kindWrite, name, adr, dat, '0, '0, '0);
    endtask

    task automatic addRead(input string name, input wbAddrT adr, input wbDataT expected);
        addRow(kindRead, name, adr, '0, '0, '0, expected);
    endtask

    task automatic addProbe(input string name, input coordT hPos, input coordT vPos,
        input colorSelT expected);
        addRow(kindProbe, name, '0, '0, hPos, vPos, wbDataT'(expected));
    endtask

    // sets an object's rectangle and style in five writes
    task automatic addObject(input string name, input wbIndexT index, input coordT hStart,
        input coordT vStart, input coordT width, input coordT height,
        input colorSelT color, input logic visible);
        addWrite({name, " hStart"}, regAddr(index, fieldHStart), wbDataT'(hStart));
        addWrite({name, " vStart"}, regAddr(index, fieldVStart), wbDataT'(vStart));
        addWrite({name, " width"}, regAddr(index, fieldWidth), wbDataT'(width));
        addWrite({name, " height"}, regAddr(index, fieldHeight), wbDataT'(height));
        addWrite({name, " style"}, regAddr(index, fieldStyle), styleWord(color, visible));
    endtask

    task automatic buildTable();
        // after reset, nothing drawn
        addProbe("reset inner probe a", 10'd400, 10'd300, backColor);
        addProbe("reset inner probe b", 10'd200, 10'd100, backColor);
        addRead("reset player style", regAddr(4'd0, fieldStyle), 32'h0);

        // window edges and border band
        addProbe("left of window", 10'd100, 10'd200, backColor);
        addProbe("right of window", 10'd785, 10'd200, backColor);
        addProbe("above window", 10'd400, 10'd20, backColor);
        addProbe("left border outer", 10'd144, 10'd200, borderColor);
        addProbe("left border inner", 10'd152, 10'd200, borderColor);
        addProbe("right border", 10'd784, 10'd300, borderColor);
        addProbe("bottom border", 10'd400, 10'd515, borderColor);
        addProbe("top border inner", 10'd400, 10'd43, borderColor);
        addProbe("just past border", 10'd153, 10'd200, backColor);

        // wall 1 covers columns 244..264, lines 135..145
        addObject("wall1", wallIndex(1), 10'd100, 10'd100, 10'd20, 10'd10, 3'd3, 1'b1);
        addProbe("wall1 top left", 10'd244, 10'd135, 3'd3);
        addProbe("wall1 bottom right", 10'd264, 10'd145, 3'd3);
        addProbe("wall1 right of box", 10'd265, 10'd145, backColor);
        addProbe("wall1 left of box", 10'd243, 10'd135, backColor);
        addWrite("wall1 hide", regAddr(wallIndex(1), fieldStyle), styleWord(3'd3, 1'b0));
        addProbe("wall1 hidden", 10'd250, 10'd140, backColor);

        // three overlapping blocks around (400, 300)
        addObject("player", 4'd0, 10'd250, 10'd260, 10'd10, 10'd10, 3'd5, 1'b1);
        addObject("wall2", wallIndex(2), 10'd200, 10'd200, 10'd100, 10'd100, 3'd2, 1'b1);
        addObject("scroll0", scrollIndex(0), 10'd240, 10'd250, 10'd30, 10'd30, 3'd7, 1'b1);
        addProbe("player wins", 10'd400, 10'd300, 3'd5);
        addWrite("player hide", regAddr(4'd0, fieldStyle), styleWord(3'd5, 1'b0));
        addProbe("wall2 wins", 10'd400, 10'd300, 3'd2);
        addWrite("wall2 hide", regAddr(wallIndex(2), fieldStyle), styleWord(3'd2, 1'b0));
        addProbe("scroll0 wins", 10'd400, 10'd300, 3'd7);

        // readback, scroll 3 lands outside the window
        addObject("scroll3", scrollIndex(3), 10'h2a5, 10'h1c3, 10'h07f, 10'h300, 3'd6, 1'b1);
        addRead("scroll3 hStart", regAddr(scrollIndex(3), fieldHStart), 32'h2a5);
        addRead("scroll3 vStart", regAddr(scrollIndex(3), fieldVStart), 32'h1c3);
        addRead("scroll3 width", regAddr(scrollIndex(3), fieldWidth), 32'h07f);
        addRead("scroll3 height", regAddr(scrollIndex(3), fieldHeight), 32'h300);
        addRead("scroll3 style", regAddr(scrollIndex(3), fieldStyle), 32'h106);
        addRead("unmapped index", regAddr(4'd12, fieldHStart), 32'h0);
        addRead("unmapped field", regAddr(scrollIndex(3), 3'd6), 32'h0);

        // wall 0 straddles the left border, columns 144..174
        addObject("wall0", wallIndex(0), 10'd0, 10'd100, 10'd30, 10'd10, 3'd4, 1'b1);
        addProbe("border over wall0", 10'd150, 10'd140, borderColor);
        addProbe("wall0 past border", 10'd160, 10'd140, 3'd4);
    endtask

    //////////////////////////////////////////////////////////////////////
    // bus and pixel drivers

    task automatic waitAck(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (wbRsp.ack !== 1'b1 && cycles < ackTimeout)
        begin
            @(negedge clk);
            cycles++;
        end
        if (wbRsp.ack !== 1'b1)
        begin
            reportFailure($sformatf("%s: the register slave never acknowledged", name));
        end
    endtask

    task automatic busTransfer(input string name, input logic we, input wbAddrT adr,
        input wbDataT dat, output wbDataT rdata);
        @(posedge clk);
        wbReq.cyc <= 1'b1;
        wbReq.stb <= 1'b1;
        wbReq.we  <= we;
        wbReq.adr <= adr;
        wbReq.dat <= dat;
        waitAck(name);
        rdata = wbRsp.dat;
        // master lets go on the edge after ack
        @(posedge clk);
        wbReq <= '0;
    endtask

    // select is registered, valid one edge after the position
    task automatic probePixel(input coordT hPos, input coordT vPos, output colorSelT result);
        @(posedge clk);
        hCount <= hPos;
        vCount <= vPos;
        @(posedge clk);
        @(negedge clk);
        result = sel;
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence

    initial
    begin
        wbDataT   rdata;
        colorSelT pixel;
        rowT      row;
        clk    = 1'b0;
        reset  = 1'b1;
        hCount = '0;
        vCount = '0;
        wbReq  = '0;
        buildTable();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < rows.size(); i++)
        begin
            row = rows[i];
            case (row.kind)
                kindWrite:
                begin
                    busTransfer(rowNames[i], 1'b1, row.adr, row.dat, rdata);
                end
                kindRead:
                begin
                    busTransfer(rowNames[i], 1'b0, row.adr, '0, rdata);
                    checkValue(rowNames[i], row.expected, rdata);
                end
                default:
                begin
                    probePixel(row.hPos, row.vPos, pixel);
                    checkValue(rowNames[i], row.expected, wbDataT'(pixel));
                end
            endcase
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- files.f
rtl/displayPkg.sv
rtl/busPkg.sv
rtl/objectRegs.sv
rtl/objectHit.sv
rtl/pixelCompositor.sv
rtl/compareDisp.sv
verification/compareDispTb.sv

//--- Bender.yml
package:
  name: compare_disp

sources:
  - rtl/displayPkg.sv
  - rtl/busPkg.sv
  - rtl/objectRegs.sv
  - rtl/objectHit.sv
  - rtl/pixelCompositor.sv
  - rtl/compareDisp.sv
  - target: test
    files:
      - verification/compareDispTb.sv
